/* include/cpu_params.svh */
//--------------------------------------
// Core widths and the bus address map
// Both region bases must be word aligned
// The pc wraps at 2**CPU_PC_W words
//--------------------------------------
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath and register file
`define CPU_DATA_W    16
`define CPU_NUM_REGS  16

// Program counter and data word index
`define CPU_PC_W      11

// External memory bus
`define CPU_ADDR_W    32
`define CPU_INST_BASE 32'h0000_1000
`define CPU_DATA_BASE 32'h0000_2000

`endif

/* design/cpu_pkg.sv */
//--------------------------------------
// Shared types of the 16-bit core
// Instruction word is opcode rs rt rd func
// The signed immediate is {rd, func}
//--------------------------------------
`include "cpu_params.svh"

package cpu_pkg;

  typedef logic signed [`CPU_DATA_W-1:0]     data_t;
  typedef logic [`CPU_ADDR_W-1:0]            addr_t;
  typedef logic [`CPU_PC_W-1:0]              pc_t;
  typedef logic [$clog2(`CPU_NUM_REGS)-1:0]  reg_idx_t;

  // Opcodes 5 to 7 are left unnamed and retire as no-ops
  typedef enum logic [2:0] {
    OP_ADDSUB = 3'd0,
    OP_SLTMUL = 3'd1,
    OP_LOAD   = 3'd2,
    OP_STORE  = 3'd3,
    OP_BEQ    = 3'd4
  } opcode_e;

  typedef struct packed {
    opcode_e  opcode;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    logic     func;
  } inst_t;

  typedef enum logic [1:0] {MEM_FETCH, MEM_LOAD, MEM_STORE} mem_op_e;
  typedef enum logic {WB_ALU, WB_MEM} wb_src_e;
  typedef enum logic [2:0] {S_FETCH, S_DECODE, S_EXEC, S_MEM, S_WB, S_DONE} ctrl_state_e;

endpackage

/* design/mem_if.sv */
//--------------------------------------
// Four-phase req/ack channel
// Fields stay stable while req is high
// No new req while ack is still high
//--------------------------------------
interface mem_if;

  logic             req;
  logic             ack;
  cpu_pkg::mem_op_e op;
  cpu_pkg::pc_t     index;
  cpu_pkg::data_t   wdata;
  // Valid with ack for fetch and load
  cpu_pkg::data_t   rdata;

  modport ctrl (
    output req, op, index, wdata,
    input  ack, rdata
  );

  modport bridge (
    input  req, op, index, wdata,
    output ack, rdata
  );

endinterface

/* design/core_ctrl.sv */
//--------------------------------------
// Instruction cycle FSM
// Fetch and memory wait for ack
// Other states take one cycle each
//--------------------------------------
`include "cpu_params.svh"

module core_ctrl
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  mem_if.ctrl     mem,
  input  pc_t     pc,
  input  data_t   alu_result,
  input  data_t   rt_val,
  output inst_t   inst,
  output logic    pc_advance,
  output logic    branch_take,
  output logic    reg_we,
  output wb_src_e wb_src,
  output logic    io_stall
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        req_q;
  logic        mem_phase;
  logic        xfer_done;
  logic        is_mem_op;

  assign mem_phase = (state == S_FETCH) || (state == S_MEM);
  assign xfer_done = req_q && mem.ack;
  assign is_mem_op = (inst.opcode == OP_LOAD) || (inst.opcode == OP_STORE);

  //--------------------------------------
  // Request fields
  //--------------------------------------
  assign mem.req   = req_q;
  assign mem.op    = (state == S_FETCH) ? MEM_FETCH :
                     (inst.opcode == OP_STORE) ? MEM_STORE : MEM_LOAD;
  // Data accesses use the low bits of rs + imm as word index
  assign mem.index = (state == S_FETCH) ? pc : pc_t'(alu_result[`CPU_PC_W-1:0]);
  assign mem.wdata = rt_val;

  //--------------------------------------
  // Next state
  //--------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      S_FETCH:  if (xfer_done) state_nxt = S_DECODE;
      S_DECODE: state_nxt = S_EXEC;
      S_EXEC:   state_nxt = is_mem_op ? S_MEM : S_WB;
      S_MEM:    if (xfer_done) state_nxt = S_WB;
      S_WB:     state_nxt = S_DONE;
      default:  state_nxt = S_FETCH;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_FETCH;
      req_q    <= 1'b0;
      inst     <= '0;
      io_stall <= 1'b1;
    end else begin
      state    <= state_nxt;
      // Low for the single cycle after done
      io_stall <= (state != S_DONE);
      if (mem_phase) begin
        if (xfer_done) begin
          req_q <= 1'b0;
        end else if (!req_q && !mem.ack) begin
          req_q <= 1'b1;
        end
      end
      if (state == S_FETCH && xfer_done) begin
        inst <= inst_t'(mem.rdata);
      end
    end
  end

  //--------------------------------------
  // Datapath controls
  //--------------------------------------
  assign pc_advance  = (state == S_EXEC);
  assign branch_take = (state == S_WB) && (inst.opcode == OP_BEQ) && (alu_result == data_t'(1));
  assign reg_we      = (state == S_WB) &&
                       (inst.opcode inside {OP_ADDSUB, OP_SLTMUL, OP_LOAD});
  assign wb_src      = (inst.opcode == OP_LOAD) ? WB_MEM : WB_ALU;

  // Four-phase rule seen across both ends of the channel
  req_hold_until_ack: assert property (
    @(posedge clk) disable iff (!rst_n) $fell(mem.req) |-> mem.ack
  );

endmodule

/* design/pc_counter.sv */
//--------------------------------------
// Program counter in word units
// Branch offset is relative to pc + 1
// Wraps modulo 2**CPU_PC_W
//--------------------------------------
`include "cpu_params.svh"

module pc_counter
  import cpu_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              advance,
  input  logic              branch_take,
  input  logic signed [4:0] offset,
  output pc_t               pc
);

  pc_t offset_ext;

  // Sign extension of the 5-bit immediate
  assign offset_ext = pc_t'(offset);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (branch_take) begin
      pc <= pc + offset_ext;
    end else if (advance) begin
      pc <= pc + 1'b1;
    end
  end

  // Increment and branch fall in different FSM states
  no_double_update: assert property (
    @(posedge clk) disable iff (!rst_n) !(advance && branch_take)
  );

endmodule

/* design/reg_file.sv */
//--------------------------------------
// Sixteen signed registers
// Two async read ports and one write port
// ALU writes rd and a load writes rt
//--------------------------------------
`include "cpu_params.svh"

module reg_file
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  inst_t   inst,
  input  logic    we,
  input  wb_src_e wb_src,
  input  data_t   alu_result,
  input  data_t   load_data,
  output data_t   rs_val,
  output data_t   rt_val
);

  data_t regs [`CPU_NUM_REGS];

  assign rs_val = regs[inst.rs];
  assign rt_val = regs[inst.rt];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      if (wb_src == WB_MEM) begin
        regs[inst.rt] <= load_data;
      end else begin
        regs[inst.rd] <= alu_result;
      end
    end
  end

  // Source select comes from the decoded instruction
  wb_src_known: assert property (
    @(posedge clk) disable iff (!rst_n) we |-> !$isunknown(wb_src)
  );

endmodule

/* design/alu.sv */
//--------------------------------------
// Execute unit with registered result
// Multiply keeps the low 16 bits
// Unused opcodes give zero
//--------------------------------------
module alu
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  inst_t inst,
  input  data_t rs_val,
  input  data_t rt_val,
  input  logic  capture,
  output data_t result
);

  logic signed [4:0] imm;
  data_t             operand_b;
  data_t             result_nxt;

  assign imm = {inst.rd, inst.func};

  // Loads and stores add the immediate to rs
  assign operand_b = (inst.opcode == OP_LOAD || inst.opcode == OP_STORE) ? data_t'(imm) : rt_val;

  always_comb begin
    case (inst.opcode)
      OP_ADDSUB: result_nxt = inst.func ? rs_val - operand_b : rs_val + operand_b;
      OP_SLTMUL: result_nxt = inst.func ? rs_val * operand_b : data_t'(rs_val < operand_b);
      OP_LOAD,
      OP_STORE:  result_nxt = rs_val + operand_b;
      OP_BEQ:    result_nxt = data_t'(rs_val == operand_b);
      default:   result_nxt = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
    end else if (capture) begin
      result <= result_nxt;
    end
  end

endmodule

/* design/mem_bridge.sv */
//--------------------------------------
// Four-phase request to valid/ready bus
// One single-beat transfer per request
// Byte address is base + 2 * index
//--------------------------------------
`include "cpu_params.svh"

module mem_bridge
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  mem_if.bridge req,
  output logic  mem_valid,
  output logic  mem_write,
  output addr_t mem_addr,
  output data_t mem_wdata,
  input  logic  mem_ready,
  input  data_t mem_rdata
);

  logic  ack_q;
  data_t rdata_q;
  logic  start;
  logic  done;
  addr_t base;

  assign start = req.req && !mem_valid && !ack_q;
  assign done  = mem_valid && mem_ready;
  assign base  = (req.op == MEM_FETCH) ? `CPU_INST_BASE : `CPU_DATA_BASE;

  assign req.ack   = ack_q;
  assign req.rdata = rdata_q;

  //--------------------------------------
  // Handshake control
  //--------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
      ack_q     <= 1'b0;
    end else if (mem_valid) begin
      if (mem_ready) begin
        mem_valid <= 1'b0;
        ack_q     <= 1'b1;
      end
    end else if (ack_q) begin
      // Release only after the controller dropped req
      if (!req.req) begin
        ack_q <= 1'b0;
      end
    end else if (req.req) begin
      mem_valid <= 1'b1;
    end
  end

  //--------------------------------------
  // Bus fields and read data
  //--------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_write <= 1'b0;
      mem_addr  <= '0;
      mem_wdata <= '0;
      rdata_q   <= '0;
    end else begin
      if (start) begin
        mem_write <= (req.op == MEM_STORE);
        mem_addr  <= base + addr_t'({req.index, 1'b0});
        mem_wdata <= req.wdata;
      end
      if (done && !mem_write) begin
        rdata_q <= mem_rdata;
      end
    end
  end

  // Back-pressure must not disturb a pending transfer
  bus_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    mem_valid && !mem_ready |=>
      mem_valid && $stable(mem_write) && $stable(mem_addr) && $stable(mem_wdata)
  );

endmodule

/* design/cpu_top.sv */
//--------------------------------------
// Top level of the 16-bit core
// Shared single-beat valid/ready bus
// io_stall pulses low per retired inst
//--------------------------------------
module cpu_top
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  output logic  io_stall,
  output logic  mem_valid,
  output logic  mem_write,
  output addr_t mem_addr,
  output data_t mem_wdata,
  input  logic  mem_ready,
  input  data_t mem_rdata
);

  mem_if bus ();

  inst_t             inst;
  pc_t               pc;
  data_t             rs_val;
  data_t             rt_val;
  data_t             alu_result;
  logic              exec_cycle;
  logic              branch_take;
  logic              reg_we;
  wb_src_e           wb_src;
  logic signed [4:0] imm;

  assign imm = {inst.rd, inst.func};

  core_ctrl i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem         (bus.ctrl),
    .pc          (pc),
    .alu_result  (alu_result),
    .rt_val      (rt_val),
    .inst        (inst),
    .pc_advance  (exec_cycle),
    .branch_take (branch_take),
    .reg_we      (reg_we),
    .wb_src      (wb_src),
    .io_stall    (io_stall)
  );

  pc_counter i_pc (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance     (exec_cycle),
    .branch_take (branch_take),
    .offset      (imm),
    .pc          (pc)
  );

  reg_file i_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .we         (reg_we),
    .wb_src     (wb_src),
    .alu_result (alu_result),
    .load_data  (bus.rdata),
    .rs_val     (rs_val),
    .rt_val     (rt_val)
  );

  // Result is captured in the execute cycle
  alu i_alu (
    .clk     (clk),
    .rst_n   (rst_n),
    .inst    (inst),
    .rs_val  (rs_val),
    .rt_val  (rt_val),
    .capture (exec_cycle),
    .result  (alu_result)
  );

  mem_bridge i_bridge (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (bus.bridge),
    .mem_valid (mem_valid),
    .mem_write (mem_write),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata)
  );

endmodule

/* dv/tb_mem_model.sv */
//--------------------------------------
// Bus memory model for the 16-bit core
// Data region is copied from data_init on reset
// Ready comes 1 to 4 cycles after valid
//--------------------------------------
`include "cpu_params.svh"

module tb_mem_model
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  mem_valid,
  input  logic  mem_write,
  input  addr_t mem_addr,
  input  data_t mem_wdata,
  output logic  mem_ready,
  output data_t mem_rdata,
  input  data_t inst_init [2048],
  input  data_t data_init [2048]
);
  timeunit 1ns;
  timeprecision 1ps;

  data_t dmem [2048];
  addr_t store_addr [16];
  data_t store_data [16];
  int    store_count;
  int    hold_errors = 0;
  int    wait_cnt;
  logic  held;
  logic  held_write;
  addr_t held_addr;
  data_t held_wdata;
  pc_t   idx;
  logic  is_data;

  assign idx     = mem_addr[`CPU_PC_W:1];
  assign is_data = (mem_addr >= `CPU_DATA_BASE);

  initial begin
    void'($urandom(32'h82b1_2c53));
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_ready   <= 1'b0;
      mem_rdata   <= '0;
      store_count <= 0;
      wait_cnt    <= 0;
      held        <= 1'b0;
      for (int i = 0; i < 2048; i++) begin
        dmem[i] <= data_init[i];
      end
    end else begin
      // Fields held over from a waiting cycle must not move
      if (held && (mem_addr !== held_addr || mem_wdata !== held_wdata ||
                   mem_write !== held_write || !mem_valid)) begin
        hold_errors <= hold_errors + 1;
        $display("Bus fields changed while a transfer waited at %0t", $time);
      end
      held       <= mem_valid && !mem_ready;
      held_addr  <= mem_addr;
      held_wdata <= mem_wdata;
      held_write <= mem_write;
      if (mem_valid && mem_ready) begin
        if (mem_write) begin
          dmem[idx] <= mem_wdata;
          store_addr[store_count[3:0]] <= mem_addr;
          store_data[store_count[3:0]] <= mem_wdata;
          store_count <= store_count + 1;
        end
        mem_ready <= 1'b0;
        wait_cnt  <= int'($urandom_range(3, 0));
      end else if (mem_valid) begin
        if (wait_cnt == 0) begin
          mem_ready <= 1'b1;
          mem_rdata <= is_data ? dmem[idx] : inst_init[idx];
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

endmodule

/* dv/tb_cpu.sv */
//--------------------------------------
// Testbench for cpu_top
// Each table row is a program run from reset
// Stores are compared against the row list
//--------------------------------------
module tb_cpu
  import cpu_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ROWS = 3;

  logic  clk;
  logic  rst_n;
  logic  io_stall;
  logic  mem_valid;
  logic  mem_write;
  addr_t mem_addr;
  data_t mem_wdata;
  logic  mem_ready;
  data_t mem_rdata;
  data_t inst_init [2048];
  data_t data_init [2048];

  data_t prog [ROWS][12];
  data_t dinit [ROWS][4];
  int    n_inst [ROWS];
  int    n_store [ROWS];
  addr_t exp_addr [ROWS][4];
  data_t exp_data [ROWS][4];
  int    errors;

  cpu_top i_dut (.*);

  tb_mem_model i_mem (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic data_t enc_i(opcode_e op, int rs, int rt, int imm);
    inst_t w;
    w.opcode = op;
    w.rs = reg_idx_t'(rs);
    w.rt = reg_idx_t'(rt);
    {w.rd, w.func} = 5'(imm);
    return data_t'(w);
  endfunction

  function automatic data_t enc_r(opcode_e op, int rs, int rt, int rd, logic func);
    return enc_i(op, rs, rt, rd * 2 + int'(func));
  endfunction

  task automatic check_data(string name, data_t got, data_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(string name, addr_t got, addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  //--------------------------------------
  // Program table
  //--------------------------------------
  task automatic build_table();
    // Arithmetic on loaded words, 300 * 250 wraps to 16'h24f8
    prog[0] = '{enc_i(OP_LOAD, 0, 1, 0), enc_i(OP_LOAD, 0, 2, 1), enc_i(OP_LOAD, 0, 3, 2),
                enc_r(OP_ADDSUB, 1, 2, 4, 0), enc_r(OP_ADDSUB, 1, 2, 5, 1),
                enc_r(OP_SLTMUL, 2, 1, 6, 0), enc_r(OP_SLTMUL, 1, 3, 7, 1),
                enc_i(OP_STORE, 0, 4, 4), enc_i(OP_STORE, 0, 5, 5), enc_i(OP_STORE, 0, 6, 6),
                enc_i(OP_STORE, 0, 7, 7), '0};
    dinit[0] = '{16'd300, 16'hfff9, 16'd250, 16'd0};
    n_inst[0] = 11;
    n_store[0] = 4;
    exp_addr[0] = '{32'h2008, 32'h200a, 32'h200c, 32'h200e};
    exp_data[0] = '{16'h0125, 16'h0133, 16'h0001, 16'h24f8};
    // Copy with negative immediates, then two no-op opcodes
    prog[1] = '{enc_i(OP_LOAD, 0, 1, 1), enc_i(OP_LOAD, 1, 2, -3), enc_i(OP_STORE, 1, 2, -1),
                enc_i(OP_STORE, 0, 2, -2), 16'ha000, 16'he000, '0, '0, '0, '0, '0, '0};
    dinit[1] = '{16'h1234, 16'd5, 16'hbeef, 16'd0};
    n_inst[1] = 6;
    n_store[1] = 2;
    exp_addr[1] = '{32'h2008, 32'h2ffc, 32'h0, 32'h0};
    exp_data[1] = '{16'hbeef, 16'hbeef, 16'h0, 16'h0};
    // Taken branch skips index 4, untaken one falls through
    prog[2] = '{enc_i(OP_LOAD, 0, 1, 0), enc_i(OP_LOAD, 0, 2, 1), enc_i(OP_LOAD, 0, 3, 2),
                enc_i(OP_BEQ, 1, 2, 1), enc_i(OP_STORE, 0, 1, 8), enc_i(OP_BEQ, 1, 3, 1),
                enc_i(OP_STORE, 0, 3, 9), enc_i(OP_STORE, 0, 1, 10), '0, '0, '0, '0};
    dinit[2] = '{16'd9, 16'd9, 16'd4, 16'd0};
    n_inst[2] = 7;
    n_store[2] = 2;
    exp_addr[2] = '{32'h2012, 32'h2014, 32'h0, 32'h0};
    exp_data[2] = '{16'h0004, 16'h0009, 16'h0, 16'h0};
  endtask

  task automatic run_row(int r);
    int   pulses;
    int   low_cycles;
    logic prev;
    // Fill words carry their index, opcode 5 keeps the code fill a no-op
    for (int i = 0; i < 2048; i++) begin
      inst_init[i] = (i < 12) ? prog[r][i] : data_t'(16'ha000 | i);
      data_init[i] = (i < 4) ? dinit[r][i] : data_t'(16'h5000 + i);
    end
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_count("io_stall after reset", int'(io_stall), 1);
    pulses = 0;
    low_cycles = 0;
    prev = 1'b1;
    while (pulses < n_inst[r]) begin
      @(posedge clk);
      if (!io_stall) begin
        low_cycles++;
        if (prev) pulses++;
      end
      prev = io_stall;
    end
    @(posedge clk);
    check_count("io_stall after last pulse", int'(io_stall), 1);
    check_count("io_stall low cycles", low_cycles, n_inst[r]);
    check_count("store count", i_mem.store_count, n_store[r]);
    for (int s = 0; s < n_store[r]; s++) begin
      check_addr("store mem_addr", i_mem.store_addr[s], exp_addr[r][s]);
      check_data("store mem_wdata", i_mem.store_data[s], exp_data[r][s]);
    end
  endtask

  //--------------------------------------
  // Main sequence and watchdog
  //--------------------------------------
  initial begin
    errors = 0;
    rst_n = 1'b0;
    build_table();
    for (int r = 0; r < ROWS; r++) begin
      run_row(r);
    end
    check_count("bus hold errors", i_mem.hold_errors, 0);
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    int limit;
    #1;
    limit = 0;
    for (int r = 0; r < ROWS; r++) begin
      limit += n_inst[r] * 40 + 10;
    end
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles with errors %0d", limit, errors);
    $display("Simulation failed");
    $finish;
  end

endmodule

/* sources.f */
+incdir+include
design/cpu_pkg.sv
design/mem_if.sv
design/core_ctrl.sv
design/pc_counter.sv
design/reg_file.sv
design/alu.sv
design/mem_bridge.sv
design/cpu_top.sv
dv/tb_mem_model.sv
dv/tb_cpu.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module tb_cpu -Mdir obj_dir \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_cpu > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
